// ==== tb.f ====
+incdir+include
src/iq_analysis_pkg.sv
src/bin_search.sv
src/hist2d_binner.sv
src/iq_classifier.sv
src/iq_analyzer.sv
verif/iq_analyzer_properties.sv
verif/tb_iq_analyzer.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench, exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_iq_analyzer -f tb.f -o Vtb_iq_analyzer \
    && ./obj_dir/Vtb_iq_analyzer \
    || { echo "build or simulation returned an error"; exit 1; }

// ==== verif/tb_iq_analyzer.sv ====
// Directed testbench for the I/Q analyzer
`default_nettype none

`include "iq_macros.svh"

module tb_iq_analyzer
    import iq_analysis_pkg::*;
();

    // worst search over 8 index bits plus the register stages around it
    localparam int WAIT_LIMIT  = 2 * `BIN_W + 12;
    localparam int N_DUMP      = 8;
    localparam int N_CLASS     = 12;  // 4 directed then random
    localparam int N_PIPE      = 6;
    localparam int N_HIST_DIR  = 9;
    localparam int N_HIST_RAND = 16;
    localparam int N_SAMPLES   = N_DUMP + N_CLASS + N_PIPE + 3 * (N_HIST_DIR + N_HIST_RAND) + 1;
    // extra slots cover the drain gap of each mode change
    localparam int MAX_CYCLES  = (N_SAMPLES + 8) * (WAIT_LIMIT + 4);

    logic          clk100;
    logic          i_arst_n;
    logic          i_sample_valid;
    iq_sample_t    i_sample;
    analyze_mode_e i_mode;
    bin_cfg_t      i_i_cfg;
    bin_cfg_t      i_q_cfg;
    class_cfg_t    i_class_cfg;
    analysis_out_t o_out;

    logic [31:0] lfsr_q = 32'h383b;
    int          cycle_cnt = 0;

    iq_analyzer u_iq_analyzer (
        .clk100         (clk100),
        .i_arst_n       (i_arst_n),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .i_mode         (i_mode),
        .i_i_cfg        (i_i_cfg),
        .i_q_cfg        (i_q_cfg),
        .i_class_cfg    (i_class_cfg),
        .o_out          (o_out)
    );

    initial begin
        clk100 = 1'b0;
        forever #10 clk100 = ~clk100;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    always @(posedge clk100) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) stop_run("run did not finish within the global cycle limit");
    end

    // taps for x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] lfsr_bits(input int nbits);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int b = 0; b < nbits; b++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic signed [31:0] rand_signed(input int nbits);
        logic [31:0] r;
        r = lfsr_bits(nbits) << (32 - nbits);
        return $signed(r) >>> (32 - nbits);  // sign extend
    endfunction

    function automatic iq_sample_t make_sample(input int i_val, input int q_val);
        iq_sample_t s;
        s.i = i_val;
        s.q = q_val;
        return s;
    endfunction

    // sign of the offset dotted with the normal that points at excited
    function automatic iq_class_e exp_class(input iq_sample_t s, input class_cfg_t c);
        longint dot;
        dot = (longint'(s.i) - longint'(c.pt_i)) * longint'(c.perp_i)
            + (longint'(s.q) - longint'(c.pt_q)) * longint'(c.perp_q);
        if (dot > 0) return CLASS_EXCITED;
        if (dot < 0) return CLASS_GROUND;
        return CLASS_LINE;
    endfunction

    function automatic logic [`BIN_W-1:0] exp_bin(input logic signed [31:0] v,
                                                  input bin_cfg_t cfg);
        longint o;
        longint w;
        longint k;
        o = cfg.origin;
        w = cfg.bin_width;
        if (longint'(v) < o) return `BIN_OUT_OF_RANGE;
        k = (longint'(v) - o) / w;
        if (k >= longint'(cfg.num_bins)) return `BIN_OUT_OF_RANGE;
        return k[`BIN_W-1:0];
    endfunction

    // boundaries, neighbours of boundaries and the extremes of the sample range
    function automatic logic signed [31:0] edge_value(input bin_cfg_t cfg, input int sel);
        longint o;
        longint w;
        longint n;
        longint v;
        o = cfg.origin;
        w = cfg.bin_width;
        n = cfg.num_bins;
        case (sel)
            0:       v = o;
            1:       v = o - 1;
            2:       v = o + w;
            3:       v = o + (n / 2) * w;
            4:       v = o + (n / 2) * w - 1;
            5:       v = o + n * w - 1;  // last value of the top bin
            6:       v = o + n * w;
            7:       v = 64'sd2147483647;
            default: v = -64'sd2147483648;
        endcase
        return v[31:0];
    endfunction

    function automatic logic signed [31:0] rand_in_span(input bin_cfg_t cfg);
        longint w;
        longint span;
        longint v;
        w    = cfg.bin_width;
        span = longint'(cfg.num_bins) * w + 4 * w;  // two bins of margin each side
        v    = longint'(cfg.origin) - 2 * w + (longint'(lfsr_bits(24)) % span);
        return v[31:0];
    endfunction

    task automatic check_sample(input iq_sample_t got, input iq_sample_t want);
        if (got !== want) begin
            stop_run($sformatf("** Error at %0t: sample I=%0d Q=%0d, expected I=%0d Q=%0d",
                               $time, got.i, got.q, want.i, want.q));
        end
    endtask

    task automatic check_class(input iq_class_e got, input iq_class_e want);
        if (got !== want) begin
            stop_run($sformatf("** Error at %0t: class %b, expected %b", $time, got, want));
        end
    endtask

    task automatic check_coord(input hist_coord_t got, input hist_coord_t want);
        if (got !== want) begin
            stop_run($sformatf("** Error at %0t: bins %0d/%0d, expected %0d/%0d", $time,
                               got.i_bin, got.q_bin, want.i_bin, want.q_bin));
        end
    endtask

    task automatic expect_latency(input int got, input int want);
        if (got != want) begin
            stop_run($sformatf("** Error at %0t: valid after %0d cycles, expected %0d",
                               $time, got, want));
        end
    endtask

    task automatic check_unused(input int used_bits);
        if ((o_out.channels >> used_bits) != '0) begin
            stop_run($sformatf("** Error at %0t: channel bits above %0d not zero",
                               $time, used_bits - 1));
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk100);
    endtask

    task automatic set_mode(input analyze_mode_e m);
        @(posedge clk100);
        i_mode <= m;
        idle(WAIT_LIMIT);  // lets the binner drain
    endtask

    task automatic strobe(input iq_sample_t s);
        @(posedge clk100);
        i_sample_valid <= 1'b1;
        i_sample       <= s;
        @(posedge clk100);
        i_sample_valid <= 1'b0;
    endtask

    // counts falling edges after the strobe where the output is stable
    task automatic wait_out(output int lat);
        lat = 0;
        do begin
            @(negedge clk100);
            lat++;
        end while (!o_out.valid && lat < WAIT_LIMIT);
        if (!o_out.valid) stop_run("no output valid arrived within the wait limit");
        if (o_out.mode !== i_mode) begin
            stop_run($sformatf("** Error at %0t: output mode %b, expected %b",
                               $time, o_out.mode, i_mode));
        end
    endtask

    task automatic test_dump();
        iq_sample_t s;
        int         lat;
        set_mode(MODE_DUMP);
        for (int n = 0; n < N_DUMP; n++) begin
            s.i = lfsr_bits(32);
            s.q = lfsr_bits(32);
            strobe(s);
            wait_out(lat);
            expect_latency(lat, 1);
            check_sample(o_out.channels, s);
        end
    endtask

    task automatic test_classify();
        iq_sample_t s;
        int         lat;
        set_mode(MODE_CLASSIFY);
        for (int n = 0; n < N_CLASS; n++) begin
            case (n)
                0:       s = make_sample(100, -50);  // the line point
                1:       s = make_sample(114, -29);  // along the line
                2:       s = make_sample(130, -70);
                3:       s = make_sample(70, -30);
                default: s = make_sample(rand_signed(20), rand_signed(20));
            endcase
            strobe(s);
            wait_out(lat);
            expect_latency(lat, `CLASS_LATENCY + 1);
            check_class(iq_class_e'(o_out.channels[1:0]), exp_class(s, i_class_cfg));
            check_unused(2);
        end
    endtask

    task automatic test_pipeline();
        iq_sample_t s [N_PIPE];
        int         got_n;
        for (int n = 0; n < N_PIPE; n++) s[n] = make_sample(rand_signed(20), rand_signed(20));
        set_mode(MODE_CLASSIFY);
        got_n = 0;
        fork
            begin
                for (int n = 0; n < N_PIPE; n++) begin
                    @(posedge clk100);
                    i_sample_valid <= 1'b1;
                    i_sample       <= s[n];
                end
                @(posedge clk100);
                i_sample_valid <= 1'b0;
            end
            begin
                for (int w = 0; w < N_PIPE + WAIT_LIMIT && got_n < N_PIPE; w++) begin
                    @(negedge clk100);
                    if (o_out.valid) begin
                        check_class(iq_class_e'(o_out.channels[1:0]),
                                    exp_class(s[got_n], i_class_cfg));
                        got_n++;
                    end
                end
            end
        join
        if (got_n != N_PIPE) stop_run("classifier returned fewer results than strobes");
    endtask

    task automatic test_hist(input bin_cfg_t cfg_i, input bin_cfg_t cfg_q);
        iq_sample_t  s;
        hist_coord_t want;
        int          lat;
        @(posedge clk100);
        i_i_cfg <= cfg_i;
        i_q_cfg <= cfg_q;
        set_mode(MODE_HIST2D);
        for (int n = 0; n < N_HIST_DIR + N_HIST_RAND; n++) begin
            if (n < N_HIST_DIR) begin
                s.i = edge_value(cfg_i, n);
                s.q = edge_value(cfg_q, N_HIST_DIR - 1 - n);
            end else begin
                s.i = rand_in_span(cfg_i);
                s.q = rand_in_span(cfg_q);
            end
            strobe(s);
            wait_out(lat);
            want.i_bin = exp_bin(s.i, cfg_i);
            want.q_bin = exp_bin(s.q, cfg_q);
            check_coord(o_out.channels[15:0], want);
            check_unused(16);
        end
    endtask

    task automatic test_unused_mode();
        set_mode(analyze_mode_e'(2'b10));
        strobe(make_sample(rand_signed(20), rand_signed(20)));
        repeat (WAIT_LIMIT) begin
            @(negedge clk100);
            if (o_out.valid) stop_run("output valid was raised in the unused mode");
        end
    endtask

    initial begin
        i_arst_n       = 1'b0;
        i_sample_valid = 1'b1;  // held high through reset so a missing reset shows on valid
        i_sample       = '0;
        i_mode         = MODE_DUMP;
        i_i_cfg        = '{num_bins: 8'd10, bin_width: 16'd100, origin: -16'sd500};
        i_q_cfg        = '{num_bins: 8'd7, bin_width: 16'd3, origin: 16'sd20};
        i_class_cfg    = '{pt_i: 32'sd100, pt_q: -32'sd50, perp_i: 32'sd3, perp_q: -32'sd2};
        repeat (2) @(posedge clk100);
        i_arst_n       <= 1'b1;
        i_sample_valid <= 1'b0;

        test_dump();
        test_classify();
        test_pipeline();
        test_hist('{num_bins: 8'd10, bin_width: 16'd100, origin: -16'sd500},
                  '{num_bins: 8'd7, bin_width: 16'd3, origin: 16'sd20});
        test_hist('{num_bins: 8'd1, bin_width: 16'd50, origin: -16'sd25},
                  '{num_bins: 8'd255, bin_width: 16'd7, origin: -16'sd1000});
        test_hist('{num_bins: 8'd255, bin_width: 16'd1, origin: -16'sd128},
                  '{num_bins: 8'd1, bin_width: 16'd65535, origin: -16'sd32768});
        test_unused_mode();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/iq_analyzer_properties.sv ====
// Output checks bound to the analyzer
`default_nettype none

`include "iq_macros.svh"

module iq_analyzer_properties
    import iq_analysis_pkg::*;
(
    input wire logic          clk100,
    input wire logic          i_arst_n,
    input wire logic          i_sample_valid,
    input wire analyze_mode_e i_mode,
    input wire bin_cfg_t      i_i_cfg,
    input wire bin_cfg_t      i_q_cfg,
    input wire analysis_out_t o_out
);

    logic [`BIN_W-1:0] i_bin_w;
    logic [`BIN_W-1:0] q_bin_w;

    assign i_bin_w = o_out.channels[15:8];
    assign q_bin_w = o_out.channels[7:0];

    valid_low_in_reset: assert property (@(posedge clk100) !i_arst_n |-> !o_out.valid)
        else $error("output valid high while reset is asserted");

    // strobe seen at this edge, result registered one edge after the pipeline
    class_latency: assert property (@(posedge clk100) disable iff (!i_arst_n)
        (i_sample_valid && i_mode == MODE_CLASSIFY) |-> ##(`CLASS_LATENCY + 1) o_out.valid)
        else $error("classify result missing at the fixed latency");

    hist_bin_legal: assert property (@(posedge clk100) disable iff (!i_arst_n)
        (o_out.valid && o_out.mode == MODE_HIST2D) |->
            ((i_bin_w < i_i_cfg.num_bins) || (i_bin_w == `BIN_OUT_OF_RANGE)) &&
            ((q_bin_w < i_q_cfg.num_bins) || (q_bin_w == `BIN_OUT_OF_RANGE)))
        else $error("bin index outside the configured bins");

endmodule

bind iq_analyzer iq_analyzer_properties u_props (
    .clk100         (clk100),
    .i_arst_n       (i_arst_n),
    .i_sample_valid (i_sample_valid),
    .i_mode         (i_mode),
    .i_i_cfg        (i_i_cfg),
    .i_q_cfg        (i_q_cfg),
    .o_out          (o_out)
);

`default_nettype wire

// ==== src/iq_analyzer.sv ====
// I/Q readout analyzer top level
`default_nettype none

`include "iq_macros.svh"

module iq_analyzer
    import iq_analysis_pkg::*;
(
    input  wire logic          clk100,
    input  wire logic          i_arst_n,
    input  wire logic          i_sample_valid,
    input  wire iq_sample_t    i_sample,
    input  wire analyze_mode_e i_mode,
    input  wire bin_cfg_t      i_i_cfg,
    input  wire bin_cfg_t      i_q_cfg,
    input  wire class_cfg_t    i_class_cfg,
    output analysis_out_t      o_out
);

    logic               coord_valid_w;
    hist_coord_t        coord_w;
    logic               class_valid_w;
    iq_class_e          class_w;

    logic               valid_n;
    logic [2*`IQ_W-1:0] chan_n;

    logic               valid_r;
    analyze_mode_e      mode_r;
    logic [2*`IQ_W-1:0] chan_r;

    hist2d_binner u_binner (
        .clk100         (clk100),
        .i_arst_n       (i_arst_n),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .i_i_cfg        (i_i_cfg),
        .i_q_cfg        (i_q_cfg),
        .o_coord_valid  (coord_valid_w),
        .o_coord        (coord_w)
    );

    iq_classifier u_classifier (
        .clk100         (clk100),
        .i_arst_n       (i_arst_n),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .i_cfg          (i_class_cfg),
        .o_class_valid  (class_valid_w),
        .o_class        (class_w)
    );

    // pick the result for the current mode, unused bits stay zero
    always_comb begin
        valid_n = 1'b0;
        chan_n  = '0;
        case (i_mode)
            MODE_DUMP: begin
                valid_n = i_sample_valid;  // straight from the input
                chan_n  = {i_sample.i, i_sample.q};
            end
            MODE_CLASSIFY: begin
                valid_n     = class_valid_w;
                chan_n[1:0] = class_w;
            end
            MODE_HIST2D: begin
                valid_n      = coord_valid_w;
                chan_n[15:0] = coord_w;
            end
            default: ;  // 2'b10 never reports
        endcase
    end

    always_ff @(posedge clk100 or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_r <= 1'b0;
            mode_r  <= MODE_DUMP;
        end else begin
            valid_r <= valid_n;
            mode_r  <= i_mode;
        end
    end

    always_ff @(posedge clk100) begin
        chan_r <= chan_n;
    end

    assign o_out = '{valid: valid_r, mode: mode_r, channels: chan_r};

endmodule

`default_nettype wire

// ==== src/iq_classifier.sv ====
// Pipelined linear state classifier
`default_nettype none

`include "iq_macros.svh"

module iq_classifier
    import iq_analysis_pkg::*;
(
    input  wire logic       clk100,
    input  wire logic       i_arst_n,
    input  wire logic       i_sample_valid,
    input  wire iq_sample_t i_sample,
    input  wire class_cfg_t i_cfg,
    output logic            o_class_valid,
    output iq_class_e       o_class
);

    logic [`CLASS_LATENCY-1:0] vld_sr;   // one bit per stage

    logic signed [`IQ_W-1:0]   d_i_r;    // offset from the line point
    logic signed [`IQ_W-1:0]   d_q_r;
    logic signed [2*`IQ_W-1:0] prod_i_r;
    logic signed [2*`IQ_W-1:0] prod_q_r;
    iq_class_e                 class_r;

    // extra bit so the sum of two full products keeps its sign
    logic signed [2*`IQ_W:0]   dot_c;

    assign dot_c = prod_i_r + prod_q_r;

    always_ff @(posedge clk100 or negedge i_arst_n) begin
        if (!i_arst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[`CLASS_LATENCY-2:0], i_sample_valid};
        end
    end

    always_ff @(posedge clk100) begin
        // stage 1
        d_i_r <= i_sample.i - i_cfg.pt_i;
        d_q_r <= i_sample.q - i_cfg.pt_q;

        // stage 2
        prod_i_r <= d_i_r * i_cfg.perp_i;
        prod_q_r <= d_q_r * i_cfg.perp_q;

        // stage 3, the normal points toward excited
        if (dot_c > 0) begin
            class_r <= CLASS_EXCITED;
        end else if (dot_c < 0) begin
            class_r <= CLASS_GROUND;
        end else begin
            class_r <= CLASS_LINE;
        end
    end

    assign o_class_valid = vld_sr[`CLASS_LATENCY-1];
    assign o_class       = class_r;

endmodule

`default_nettype wire

// ==== src/hist2d_binner.sv ====
// 2-D bin coordinates from two axis searches
`default_nettype none

`include "iq_macros.svh"

module hist2d_binner
    import iq_analysis_pkg::*;
(
    input  wire logic        clk100,
    input  wire logic        i_arst_n,
    input  wire logic        i_sample_valid,
    input  wire iq_sample_t  i_sample,
    input  wire bin_cfg_t    i_i_cfg,
    input  wire bin_cfg_t    i_q_cfg,
    output logic             o_coord_valid,
    output hist_coord_t      o_coord
);

    logic              busy_r;
    logic              i_found_r;
    logic              q_found_r;
    logic              coord_valid_r;
    logic [`BIN_W-1:0] i_bin_r;
    logic [`BIN_W-1:0] q_bin_r;

    logic              start_c;
    logic              all_done_c;
    logic              i_done_w;
    logic              q_done_w;
    logic [`BIN_W-1:0] i_bin_w;
    logic [`BIN_W-1:0] q_bin_w;

    // strobes while busy are dropped here
    assign start_c    = i_sample_valid && !busy_r;
    assign all_done_c = busy_r && (i_found_r || i_done_w) && (q_found_r || q_done_w);

    bin_search u_i_search (
        .clk100   (clk100),
        .i_arst_n (i_arst_n),
        .i_start  (start_c),
        .i_value  (i_sample.i),
        .i_cfg    (i_i_cfg),
        .o_done   (i_done_w),
        .o_bin    (i_bin_w)
    );

    bin_search u_q_search (
        .clk100   (clk100),
        .i_arst_n (i_arst_n),
        .i_start  (start_c),
        .i_value  (i_sample.q),
        .i_cfg    (i_q_cfg),
        .o_done   (q_done_w),
        .o_bin    (q_bin_w)
    );

    always_ff @(posedge clk100 or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_r        <= 1'b0;
            i_found_r     <= 1'b0;
            q_found_r     <= 1'b0;
            coord_valid_r <= 1'b0;
        end else begin
            coord_valid_r <= all_done_c;  // one cycle after the later finish
            if (start_c) begin
                busy_r    <= 1'b1;
                i_found_r <= 1'b0;
                q_found_r <= 1'b0;
            end else begin
                if (all_done_c) busy_r <= 1'b0;
                if (i_done_w) i_found_r <= 1'b1;
                if (q_done_w) q_found_r <= 1'b1;
            end
        end
    end

    // each axis latches its own index, in either order
    always_ff @(posedge clk100) begin
        if (i_done_w) i_bin_r <= i_bin_w;
        if (q_done_w) q_bin_r <= q_bin_w;
    end

    assign o_coord_valid = coord_valid_r;
    assign o_coord       = '{i_bin: i_bin_r, q_bin: q_bin_r};

endmodule

`default_nettype wire

// ==== src/bin_search.sv ====
// Binary-search bin finder, one axis
`default_nettype none

`include "iq_macros.svh"

module bin_search
    import iq_analysis_pkg::*;
(
    input  wire logic                    clk100,
    input  wire logic                    i_arst_n,
    input  wire logic                    i_start,
    input  wire logic signed [`IQ_W-1:0] i_value,
    input  wire bin_cfg_t                i_cfg,
    output logic                         o_done,
    output logic [`BIN_W-1:0]            o_bin
);

    // room for origin + 255 * 65535 and any 32-bit sample
    localparam int BND_W = `IQ_W + 2;

    search_state_e state_r;
    search_state_e state_n;

    logic signed [`IQ_W-1:0]   val_r;
    logic [`BIN_W-1:0]         lo_r;      // lowest bin still possible
    logic [`BIN_W-1:0]         hi_r;      // highest bin still possible
    logic [`BIN_W-1:0]         bin_r;
    logic signed [BND_W-1:0]   bound_r;

    logic [`BIN_W:0]           mid_sum_c;
    logic [`BIN_W-1:0]         mid_c;
    logic [`BIN_W-1:0]         hi_dn_c;
    logic [`BIN_W-1:0]         idx_sel_c;
    logic [`BIN_W+`CFG_W-1:0]  prod_c;
    logic signed [BND_W-1:0]   bound_c;
    logic signed [BND_W-1:0]   origin_c;
    logic signed [BND_W-1:0]   val_c;
    logic                      oor_c;
    logic                      go_up_c;
    logic                      conv_c;

    // upper middle of the window, so a go-up always shrinks it
    assign mid_sum_c = {1'b0, lo_r} + {1'b0, hi_r} + {{`BIN_W{1'b0}}, 1'b1};
    assign mid_c     = mid_sum_c[`BIN_W:1];
    assign hi_dn_c   = mid_c - 8'd1;

    // one multiplier: top edge during range check, mid edge otherwise
    assign idx_sel_c = (state_r == SRCH_RANGE) ? i_cfg.num_bins : mid_c;
    assign prod_c    = idx_sel_c * i_cfg.bin_width;
    assign origin_c  = BND_W'(i_cfg.origin);
    assign bound_c   = origin_c + $signed(BND_W'(prod_c));
    assign val_c     = BND_W'(val_r);

    assign oor_c   = (val_c < origin_c) || (val_c >= bound_c);
    assign go_up_c = (val_c >= bound_r);  // on the edge counts as the higher bin
    assign conv_c  = go_up_c ? (mid_c == hi_r) : (hi_dn_c == lo_r);

    always_comb begin
        state_n = state_r;
        case (state_r)
            SRCH_IDLE:  if (i_start) state_n = SRCH_RANGE;
            SRCH_RANGE: begin
                if (oor_c || (i_cfg.num_bins == 8'd1)) begin
                    state_n = SRCH_DONE;
                end else begin
                    state_n = SRCH_BOUND;
                end
            end
            SRCH_BOUND: state_n = SRCH_CMP;
            SRCH_CMP:   state_n = conv_c ? SRCH_DONE : SRCH_BOUND;
            SRCH_DONE:  state_n = SRCH_IDLE;
            default:    state_n = SRCH_IDLE;
        endcase
    end

    always_ff @(posedge clk100 or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r <= SRCH_IDLE;
        end else begin
            state_r <= state_n;
        end
    end

    always_ff @(posedge clk100) begin
        case (state_r)
            SRCH_IDLE: begin
                if (i_start) val_r <= i_value;  // hold the sample for the search
            end
            SRCH_RANGE: begin
                lo_r  <= '0;
                hi_r  <= i_cfg.num_bins - 8'd1;
                bin_r <= oor_c ? `BIN_OUT_OF_RANGE : '0;
            end
            SRCH_BOUND: bound_r <= bound_c;
            SRCH_CMP: begin
                if (go_up_c) begin
                    lo_r  <= mid_c;
                    bin_r <= mid_c;
                end else begin
                    hi_r  <= hi_dn_c;
                    bin_r <= lo_r;
                end
            end
            default: ;
        endcase
    end

    assign o_done = (state_r == SRCH_DONE);
    assign o_bin  = bin_r;

endmodule

`default_nettype wire

// ==== src/iq_analysis_pkg.sv ====
// I/Q analyzer types
`default_nettype none

`include "iq_macros.svh"

package iq_analysis_pkg;

    // one readout sample, I in the upper half
    typedef struct packed {
        logic signed [`IQ_W-1:0] i;
        logic signed [`IQ_W-1:0] q;
    } iq_sample_t;

    // per-axis binning setup
    typedef struct packed {
        logic [`BIN_W-1:0]        num_bins;   // 1 to 255
        logic [`CFG_W-1:0]        bin_width;  // at least 1
        logic signed [`CFG_W-1:0] origin;     // lower edge of bin 0
    } bin_cfg_t;

    // decision line: a point on it and a normal pointing at excited
    typedef struct packed {
        logic signed [`IQ_W-1:0] pt_i;
        logic signed [`IQ_W-1:0] pt_q;
        logic signed [`IQ_W-1:0] perp_i;
        logic signed [`IQ_W-1:0] perp_q;
    } class_cfg_t;

    typedef struct packed {
        logic [`BIN_W-1:0] i_bin;
        logic [`BIN_W-1:0] q_bin;
    } hist_coord_t;

    typedef enum logic [1:0] {
        CLASS_GROUND  = 2'b01,
        CLASS_EXCITED = 2'b10,
        CLASS_LINE    = 2'b11
    } iq_class_e;

    typedef enum logic [1:0] {
        MODE_DUMP     = 2'b00,
        MODE_CLASSIFY = 2'b01,
        MODE_HIST2D   = 2'b11  // 2'b10 left unused
    } analyze_mode_e;

    typedef struct packed {
        logic                  valid;
        analyze_mode_e         mode;
        logic [2*`IQ_W-1:0]    channels;
    } analysis_out_t;

    // bin finder states
    typedef enum logic [2:0] {
        SRCH_IDLE,
        SRCH_RANGE,
        SRCH_BOUND,
        SRCH_CMP,
        SRCH_DONE
    } search_state_e;

endpackage

`default_nettype wire

// ==== include/iq_macros.svh ====
// I/Q analyzer widths and fixed codes

`ifndef IQ_MACROS_SVH
`define IQ_MACROS_SVH

// sample width per axis
`define IQ_W 32

// bin index width, one index per axis
`define BIN_W 8

// bin width and origin width
`define CFG_W 16

// index given for a value outside every bin
`define BIN_OUT_OF_RANGE 8'hFF

// strobe to classifier result, in cycles
`define CLASS_LATENCY 3

`endif
